// File: cmd_sched.f
hdl/cmd_sched_pkg.sv
hdl/cmd_fifo.sv
hdl/cmd_scheduler.sv
hdl/bus_reg_bank.sv
hdl/cmd_sched_top.sv
testbench/cmd_sched_checker.sv
testbench/cmd_sched_tb.sv

// File: hdl/bus_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module bus_reg_bank (
	input wire logic clk,
	input wire logic rst,
	input wire cmd_sched_pkg::bus_req_t bus,
	input wire logic [cmd_sched_pkg::REG_AW-1:0] rd_addr,
	output logic [cmd_sched_pkg::DATA_W-1:0] rd_data
);

	localparam logic [cmd_sched_pkg::ADDR_W-1:0] addr_limit =
		cmd_sched_pkg::ADDR_W'(cmd_sched_pkg::REG_COUNT);

	logic [cmd_sched_pkg::DATA_W-1:0] regs [cmd_sched_pkg::REG_COUNT];

	logic addr_hit;
	logic wr_hit;
	logic [cmd_sched_pkg::REG_AW-1:0] wr_idx;

	// decode only the low bits once the range check has passed
	assign addr_hit = (bus.addr < addr_limit);
	assign wr_hit = bus.en && bus.wr && addr_hit;
	assign wr_idx = bus.addr[cmd_sched_pkg::REG_AW-1:0];

	// register file, cleared on reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < cmd_sched_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[wr_idx] <= bus.data;
		end
	end

	// host read port, one cycle latency
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			rd_data <= regs[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: hdl/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr,
	input wire cmd_sched_pkg::cmd_t din,
	output logic full,
	input wire logic rd_en,
	output cmd_sched_pkg::cmd_t dout,
	output logic valid,
	output logic empty
);

	// occupancy needs one bit more than the pointers
	localparam logic [cmd_sched_pkg::FIFO_AW:0] count_full =
		(cmd_sched_pkg::FIFO_AW + 1)'(cmd_sched_pkg::FIFO_DEPTH);

	cmd_sched_pkg::cmd_t mem [cmd_sched_pkg::FIFO_DEPTH];

	logic [cmd_sched_pkg::FIFO_AW-1:0] wr_ptr;
	logic [cmd_sched_pkg::FIFO_AW-1:0] rd_ptr;
	logic [cmd_sched_pkg::FIFO_AW:0] count;

	logic push;
	logic pop;

	assign full = (count == count_full);
	assign empty = (count == '0);

	// a push while full is simply lost
	assign push = wr && !full;
	assign pop = rd_en && !empty;

	// storage array
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (push && !pop) begin
			count <= count + 1'b1;
		end else if (pop && !push) begin
			count <= count - 1'b1;
		end
	end

	// head entry appears one cycle after the pop
	always_ff @(posedge clk) begin
		if (pop) begin
			dout <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= pop;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cmd_sched_pkg.sv
`default_nettype none

package cmd_sched_pkg;

	// time base and command bus widths
	localparam int TIME_W = 32;
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	// command fifo sizing
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = 3;

	// register bank on the command bus
	// addresses at or above REG_COUNT are ignored by the bank
	localparam int REG_COUNT = 8;
	localparam int REG_AW = 3;

	// one host command of 80 bits
	// issue_time sits in the top bits, data in the bottom bits
	typedef struct packed {
		logic [TIME_W-1:0] issue_time;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} cmd_t;

	// command bus as seen by every target
	// en and wr pulse together for a single cycle per write
	typedef struct packed {
		logic en;
		logic wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} bus_req_t;

	// scheduler control states
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_fetch = 2'd1,
		st_fifo_wait = 2'd2,
		st_exec = 2'd3
	} sched_state_t;

endpackage

`default_nettype wire

// File: hdl/cmd_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sched_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic cmd_wr,
	input wire cmd_sched_pkg::cmd_t cmd_in,
	output logic cmd_full,
	output cmd_sched_pkg::bus_req_t bus,
	output logic [cmd_sched_pkg::TIME_W-1:0] now,
	input wire logic [cmd_sched_pkg::REG_AW-1:0] rd_addr,
	output logic [cmd_sched_pkg::DATA_W-1:0] rd_data
);

	// fifo to scheduler
	cmd_sched_pkg::cmd_t cmd_dout;
	logic cmd_valid;
	logic cmd_empty;
	logic cmd_rd_en;

	cmd_fifo cmd_fifo_i (
		.clk(clk),
		.rst(rst),
		.wr(cmd_wr),
		.din(cmd_in),
		.full(cmd_full),
		.rd_en(cmd_rd_en),
		.dout(cmd_dout),
		.valid(cmd_valid),
		.empty(cmd_empty)
	);

	cmd_scheduler cmd_scheduler_i (
		.clk(clk),
		.rst(rst),
		.cmd_dout(cmd_dout),
		.cmd_valid(cmd_valid),
		.cmd_empty(cmd_empty),
		.cmd_rd_en(cmd_rd_en),
		.bus(bus),
		.now(now)
	);

	// single target on the command bus for now
	bus_reg_bank bus_reg_bank_i (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: hdl/cmd_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_scheduler (
	input wire logic clk,
	input wire logic rst,
	input wire cmd_sched_pkg::cmd_t cmd_dout,
	input wire logic cmd_valid,
	input wire logic cmd_empty,
	output logic cmd_rd_en,
	output cmd_sched_pkg::bus_req_t bus,
	output logic [cmd_sched_pkg::TIME_W-1:0] now
);

	cmd_sched_pkg::sched_state_t state;
	cmd_sched_pkg::sched_state_t next_state;

	// command currently waiting for its issue time
	cmd_sched_pkg::cmd_t cur_cmd;

	logic latch_cmd;
	logic time_due;
	logic issue;

	// state register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cmd_sched_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	// free running time base
	// held at zero in idle, so the first fetch cycle reads 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			now <= '0;
		end else if (state == cmd_sched_pkg::st_idle) begin
			now <= '0;
		end else begin
			now <= now + 1'b1;
		end
	end

	// a late command goes out at once
	assign time_due = (now >= cur_cmd.issue_time);

	// next state and control strobes
	always_comb begin
		next_state = state;
		cmd_rd_en = 1'b0;
		latch_cmd = 1'b0;
		issue = 1'b0;
		case (state)
			cmd_sched_pkg::st_idle: begin
				next_state = cmd_sched_pkg::st_fetch;
			end
			cmd_sched_pkg::st_fetch: begin
				// pop only when something is queued
				if (!cmd_empty) begin
					cmd_rd_en = 1'b1;
					next_state = cmd_sched_pkg::st_fifo_wait;
				end
			end
			cmd_sched_pkg::st_fifo_wait: begin
				// fifo output is valid in this cycle
				latch_cmd = 1'b1;
				next_state = cmd_sched_pkg::st_exec;
			end
			cmd_sched_pkg::st_exec: begin
				if (time_due) begin
					issue = 1'b1;
					next_state = cmd_sched_pkg::st_fetch;
				end
			end
			default: begin
				next_state = cmd_sched_pkg::st_idle;
			end
		endcase
	end

	// holding register for the popped command
	always_ff @(posedge clk) begin
		if (latch_cmd && cmd_valid) begin
			cur_cmd <= cmd_dout;
		end
	end

	// address and data follow the held command
	// en and wr only in the issue cycle
	always_comb begin
		bus.en = issue;
		bus.wr = issue;
		bus.addr = cur_cmd.addr;
		bus.data = cur_cmd.data;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the cmd_sched simulation with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
	--top-module cmd_sched_tb \
	-f cmd_sched.f \
	-o cmd_sched_sim \
	&& ./obj_dir/cmd_sched_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"

grep -q "^TESTS PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

exit 0

// File: testbench/cmd_sched_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sched_checker (
	input wire logic clk,
	input wire logic rst,
	input wire cmd_sched_pkg::bus_req_t bus,
	input wire logic cmd_rd_en,
	input wire cmd_sched_pkg::sched_state_t state,
	input wire logic [cmd_sched_pkg::TIME_W-1:0] now,
	input wire cmd_sched_pkg::cmd_t cur_cmd
);

	// one issue cycle per command, never back to back
	single_issue: assert property (@(posedge clk) disable iff (rst)
		bus.en |=> !bus.en)
		else $error("bus enable high in two consecutive cycles");

	// every bus access is a write
	en_is_write: assert property (@(posedge clk) disable iff (rst)
		bus.en |-> bus.wr)
		else $error("bus enable without bus write");

	// a pop always moves on to the fifo wait state
	pop_to_wait: assert property (@(posedge clk) disable iff (rst)
		cmd_rd_en |=> (state == cmd_sched_pkg::st_fifo_wait))
		else $error("fifo read not followed by the fifo wait state");

	// never issue ahead of time
	not_early: assert property (@(posedge clk) disable iff (rst)
		bus.en |-> (now >= cur_cmd.issue_time))
		else $error("command issued before its issue time");

endmodule

bind cmd_scheduler cmd_sched_checker checker_i (
	.clk(clk),
	.rst(rst),
	.bus(bus),
	.cmd_rd_en(cmd_rd_en),
	.state(state),
	.now(now),
	.cur_cmd(cur_cmd)
);

`default_nettype wire

// File: testbench/cmd_sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sched_tb;

	// one row of the stimulus table
	typedef struct {
		string name;
		int push_cyc;
		logic [31:0] issue_time;
		logic [15:0] addr;
		logic [31:0] data;
		bit late;
		int ahead;
		bit drop;
	} entry_t;

	logic clk;
	logic rst;
	logic cmd_wr;
	cmd_sched_pkg::cmd_t cmd_in;
	logic cmd_full;
	cmd_sched_pkg::bus_req_t bus;
	logic [cmd_sched_pkg::TIME_W-1:0] now;
	logic [cmd_sched_pkg::REG_AW-1:0] rd_addr;
	logic [cmd_sched_pkg::DATA_W-1:0] rd_data;

	entry_t tbl[$];

	// issues seen on the command bus
	logic [31:0] mon_now[$];
	logic [15:0] mon_addr[$];
	logic [31:0] mon_data[$];
	logic mon_wr[$];

	int checks;
	int errors;
	int limit_cycles;

	cmd_sched_top dut_i (
		.clk(clk),
		.rst(rst),
		.cmd_wr(cmd_wr),
		.cmd_in(cmd_in),
		.cmd_full(cmd_full),
		.bus(bus),
		.now(now),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	always #4 clk = ~clk;

	// sampled mid cycle where the bus has settled
	always @(negedge clk) begin
		if (rst) begin
			if (bus.en) begin
				errors++;
				$display("bus enable was high during reset at %0t", $time);
			end
		end else if (bus.en) begin
			mon_now.push_back(now);
			mon_addr.push_back(bus.addr);
			mon_data.push_back(bus.data);
			mon_wr.push_back(bus.wr);
		end
	end

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed", name);
		end
	endtask

	task automatic add_entry(input string name, input int push_cyc, input logic [31:0] t,
		input logic [15:0] addr, input logic [31:0] data, input bit late, input int ahead,
		input bit drop);
		entry_t e;
		e.name = name;
		e.push_cyc = push_cyc;
		e.issue_time = t;
		e.addr = addr;
		e.data = data;
		e.late = late;
		e.ahead = ahead;
		e.drop = drop;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		logic [31:0] times [6];
		logic [31:0] tmp;
		logic [15:0] addrs [6];
		logic [15:0] a;
		addrs = '{16'd0, 16'd1, 16'd2, 16'd3, 16'd1, 16'd1};
		for (int i = 0; i < 6; i++) begin
			times[i] = 32'd40 + ($urandom % 80);
		end
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5 - i; j++) begin
				if (times[j] > times[j+1]) begin
					tmp = times[j];
					times[j] = times[j+1];
					times[j+1] = tmp;
				end
			end
		end
		// keep neighbours far enough apart to issue on the exact cycle
		for (int i = 1; i < 6; i++) begin
			if (times[i] < times[i-1] + 32'd4) begin
				times[i] = times[i-1] + 32'd4;
			end
		end
		for (int i = 0; i < 6; i++) begin
			add_entry($sformatf("exact_%0d", i), 2 + i, times[i], addrs[i], $urandom, 0, 0, 0);
		end
		// already past due when pushed, first one goes out of range
		add_entry("late_0", 200, 32'd10, 16'd9, $urandom, 1, 0, 0);
		add_entry("late_1", 201, 32'd20, 16'd4, $urandom, 1, 1, 0);
		// head waits in exec while ten more fill the fifo
		add_entry("ovf_head", 240, 32'd500, 16'd6, $urandom, 0, 0, 0);
		for (int i = 0; i < 10; i++) begin
			if (i == 3) begin
				a = 16'h0100;
			end else if (i % 2 == 1) begin
				a = 16'd7;
			end else begin
				a = 16'd6;
			end
			add_entry($sformatf("ovf_%0d", i), 250 + i, 32'd510 + 32'(10 * i), a, $urandom,
				0, 0, i >= 8);
		end
	endtask

	function automatic int compute_limit();
		logic [31:0] max_t;
		max_t = '0;
		foreach (tbl[i]) begin
			if (!tbl[i].drop && tbl[i].issue_time > max_t) begin
				max_t = tbl[i].issue_time;
			end
		end
		return int'(max_t) + 200;
	endfunction

	task automatic wait_now(input int cyc);
		while (now != 32'(cyc)) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic read_reg(input logic [2:0] idx, output logic [31:0] val);
		rd_addr = idx;
		@(posedge clk);
		#1;
		val = rd_data;
	endtask

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the run did not complete within %0d cycles", limit_cycles);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int n_acc;
		int k;
		int err_before;
		logic full_seen;
		logic [31:0] rd_val;
		logic [31:0] exp_regs [8];
		clk = 1'b0;
		rst = 1'b1;
		cmd_wr = 1'b0;
		cmd_in = '0;
		rd_addr = '0;
		checks = 0;
		errors = 0;
		limit_cycles = 0;
		void'($urandom(32'h0d3671a7));
		build_table();
		limit_cycles = compute_limit();

		repeat (4) @(posedge clk);
		#1;
		err_before = errors;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_val("reset_now_zero", 64'd0, 64'(now));
		report_test("reset_start", err_before);

		foreach (tbl[i]) begin
			wait_now(tbl[i].push_cyc);
			err_before = errors;
			full_seen = cmd_full;
			cmd_in.issue_time = tbl[i].issue_time;
			cmd_in.addr = tbl[i].addr;
			cmd_in.data = tbl[i].data;
			cmd_wr = 1'b1;
			@(posedge clk);
			#1;
			cmd_wr = 1'b0;
			check_val({tbl[i].name, "_full"}, 64'(tbl[i].drop), 64'(full_seen));
			if (tbl[i].drop) begin
				report_test(tbl[i].name, err_before);
			end
		end

		n_acc = 0;
		foreach (tbl[i]) begin
			if (!tbl[i].drop) begin
				n_acc++;
			end
		end
		while (mon_now.size() < n_acc) begin
			@(posedge clk);
		end
		// long enough for a wrongly kept overflow entry to show up
		repeat (30) @(posedge clk);
		#1;
		check_val("no_extra_issue", 64'(n_acc), 64'(mon_now.size()));

		k = 0;
		foreach (tbl[i]) begin
			if (!tbl[i].drop) begin
				err_before = errors;
				check_val({tbl[i].name, "_addr"}, 64'(tbl[i].addr), 64'(mon_addr[k]));
				check_val({tbl[i].name, "_data"}, 64'(tbl[i].data), 64'(mon_data[k]));
				check_val({tbl[i].name, "_wr"}, 64'd1, 64'(mon_wr[k]));
				if (tbl[i].late) begin
					check_val({tbl[i].name, "_window"}, 64'd1,
						64'((mon_now[k] >= tbl[i].issue_time) &&
						(mon_now[k] <= 32'(tbl[i].push_cyc + 4 + 3 * tbl[i].ahead))));
				end else begin
					check_val({tbl[i].name, "_time"}, 64'(tbl[i].issue_time), 64'(mon_now[k]));
				end
				report_test(tbl[i].name, err_before);
				k++;
			end
		end

		// last accepted write to each in-range address wins
		for (int a = 0; a < 8; a++) begin
			exp_regs[a] = '0;
		end
		foreach (tbl[i]) begin
			if (!tbl[i].drop && tbl[i].addr < 16'd8) begin
				exp_regs[tbl[i].addr[2:0]] = tbl[i].data;
			end
		end
		err_before = errors;
		for (int a = 0; a < 8; a++) begin
			read_reg(3'(a), rd_val);
			check_val($sformatf("reg_%0d", a), 64'(exp_regs[a]), 64'(rd_val));
		end
		report_test("reg_bank", err_before);

		// second reset in the middle of the run
		err_before = errors;
		k = mon_now.size();
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		check_val("reset_bus_en", 64'd0, 64'(bus.en));
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_val("restart_now_0", 64'd0, 64'(now));
		@(posedge clk);
		#1;
		check_val("restart_now_1", 64'd1, 64'(now));
		read_reg(3'd0, rd_val);
		check_val("reset_reg_0", 64'd0, 64'(rd_val));
		check_val("reset_no_issue", 64'(k), 64'(mon_now.size()));
		report_test("reset_restart", err_before);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
